// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Bus source selects
    localparam int SET_SB_TO_ACC      = 0;
    localparam int SET_SB_TO_X        = 1;
    localparam int SET_SB_TO_Y        = 2;
    localparam int SET_SB_TO_ALU      = 3;
    localparam int SET_DB_TO_ACC      = 4;
    localparam int SET_DB_TO_SB       = 5;
    localparam int SET_DB_HIGH        = 6;
    localparam int SET_DB_TO_DATA     = 7;

    // ALU operand selects
    localparam int SET_INPUT_A_TO_SB  = 8;
    localparam int SET_INPUT_A_TO_LOW = 9;
    localparam int SET_INPUT_B_TO_DB  = 10;
    localparam int SET_ALU_CARRY_HIGH = 11;

    // ALU operation and result capture
    localparam int ALU_ADD            = 12;
    localparam int ALU_ROT            = 13;
    localparam int LOAD_ALU           = 14;
    localparam int LOAD_CARRY         = 15;

    // Register loads, all taken from SB
    localparam int SET_ACC_TO_SB      = 16;
    localparam int LOAD_X             = 17;
    localparam int LOAD_Y             = 18;

    // Program counter and address bus
    localparam int PC_INC             = 19;
    localparam int SET_ADH_TO_PCH     = 20;
    localparam int SET_ADL_TO_PCL     = 21;
    localparam int LOAD_ABH           = 22;
    localparam int LOAD_ABL           = 23;

    localparam int NUMFLAGS           = 24;

    typedef logic [NUMFLAGS-1:0] ctrl_flags_t;

    // Step number inside one instruction
    typedef logic [2:0] step_t;

    // 6502 opcode bytes
    localparam logic [7:0] OP_ASL_A   = 8'h0A;
    localparam logic [7:0] OP_ROL_A   = 8'h2A;
    localparam logic [7:0] OP_ROR_A   = 8'h6A;
    localparam logic [7:0] OP_LSR_A   = 8'h4A;
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_INY     = 8'hC8;
    localparam logic [7:0] OP_DEX     = 8'hCA;
    localparam logic [7:0] OP_DEY     = 8'h88;
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_NOP     = 8'hEA;

    // Programmer visible state
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic       carry;
    } regs_t;

    localparam logic [15:0] RESET_VECTOR = 16'h0000;

endpackage

`default_nettype wire

// ==== logic/implied_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

module implied_decode (
    input  logic [7:0]           opcode,
    input  cpu_pkg::step_t       step,
    input  logic                 carry,
    output cpu_pkg::ctrl_flags_t flags
);
    import cpu_pkg::*;

    // Final step of every instruction moves on to the next opcode
    function automatic ctrl_flags_t fetch_flags();
        ctrl_flags_t f;
        f = '0;
        f[PC_INC] = 1'b1;
        f[SET_ADH_TO_PCH] = 1'b1;
        f[SET_ADL_TO_PCL] = 1'b1;
        f[LOAD_ABH] = 1'b1;
        f[LOAD_ABL] = 1'b1;
        return f;
    endfunction

    always_comb begin
        flags = '0;
        case (opcode)
            OP_ASL_A, OP_ROL_A: begin
                if (step == 3'd0) begin
                    // A plus A, with old carry rotated in for ROL
                    flags[SET_SB_TO_ACC] = 1'b1;
                    flags[SET_DB_TO_ACC] = 1'b1;
                    flags[SET_INPUT_A_TO_SB] = 1'b1;
                    flags[SET_INPUT_B_TO_DB] = 1'b1;
                    flags[SET_ALU_CARRY_HIGH] = (opcode == OP_ROL_A) ? carry : 1'b0;
                    flags[ALU_ADD] = 1'b1;
                    flags[LOAD_ALU] = 1'b1;
                end else if (step == 3'd1) begin
                    flags = fetch_flags();
                    flags[SET_SB_TO_ALU] = 1'b1;
                    flags[SET_ACC_TO_SB] = 1'b1;
                    flags[LOAD_CARRY] = 1'b1;
                end
            end
            OP_ROR_A, OP_LSR_A: begin
                if (step == 3'd0) begin
                    // Right rotate, LSR shifts in a zero
                    flags[SET_SB_TO_ACC] = 1'b1;
                    flags[SET_INPUT_A_TO_SB] = 1'b1;
                    flags[SET_ALU_CARRY_HIGH] = (opcode == OP_ROR_A) ? carry : 1'b0;
                    flags[ALU_ROT] = 1'b1;
                    flags[LOAD_ALU] = 1'b1;
                end else if (step == 3'd1) begin
                    flags = fetch_flags();
                    flags[SET_SB_TO_ALU] = 1'b1;
                    flags[SET_ACC_TO_SB] = 1'b1;
                    flags[LOAD_CARRY] = 1'b1;
                end
            end
            OP_INX, OP_INY: begin
                if (step == 3'd0) begin
                    // Zero plus register plus carry in
                    flags[SET_SB_TO_X] = (opcode == OP_INX);
                    flags[SET_SB_TO_Y] = (opcode == OP_INY);
                    flags[SET_DB_TO_SB] = 1'b1;
                    flags[SET_INPUT_B_TO_DB] = 1'b1;
                    flags[SET_INPUT_A_TO_LOW] = 1'b1;
                    flags[SET_ALU_CARRY_HIGH] = 1'b1;
                    flags[ALU_ADD] = 1'b1;
                    flags[LOAD_ALU] = 1'b1;
                end else if (step == 3'd1) begin
                    flags = fetch_flags();
                    flags[SET_SB_TO_ALU] = 1'b1;
                    flags[LOAD_X] = (opcode == OP_INX);
                    flags[LOAD_Y] = (opcode == OP_INY);
                end
            end
            OP_DEX, OP_DEY: begin
                if (step == 3'd0) begin
                    // Register plus FF
                    flags[SET_SB_TO_X] = (opcode == OP_DEX);
                    flags[SET_SB_TO_Y] = (opcode == OP_DEY);
                    flags[SET_DB_HIGH] = 1'b1;
                    flags[SET_INPUT_A_TO_SB] = 1'b1;
                    flags[SET_INPUT_B_TO_DB] = 1'b1;
                    flags[ALU_ADD] = 1'b1;
                    flags[LOAD_ALU] = 1'b1;
                end else if (step == 3'd1) begin
                    flags = fetch_flags();
                    flags[SET_SB_TO_ALU] = 1'b1;
                    flags[LOAD_X] = (opcode == OP_DEX);
                    flags[LOAD_Y] = (opcode == OP_DEY);
                end
            end
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
                if (step == 3'd0) begin
                    // Step past the operand byte
                    flags = fetch_flags();
                end else if (step == 3'd1) begin
                    // Operand from the data latch through DB onto SB
                    flags[SET_DB_TO_DATA] = 1'b1;
                    flags[SET_DB_TO_SB] = 1'b1;
                    flags[SET_ACC_TO_SB] = (opcode == OP_LDA_IMM);
                    flags[LOAD_X] = (opcode == OP_LDX_IMM);
                    flags[LOAD_Y] = (opcode == OP_LDY_IMM);
                end else if (step == 3'd2) begin
                    flags = fetch_flags();
                end
            end
            default: begin
                // NOP and every unsupported byte
                if (step == 3'd1) begin
                    flags = fetch_flags();
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cycle_sequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

module cycle_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic [7:0]     data_in,
    output logic [7:0]     opcode,
    output cpu_pkg::step_t step,
    output logic           sync
);
    import cpu_pkg::*;

    logic last_step;

    // Immediate loads need an extra step for the operand
    always_comb begin
        case (opcode)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
                last_step = (step == step_t'(2));
            end
            default: begin
                last_step = (step == step_t'(1));
            end
        endcase
    end

    // Wrap at the final step and take the next opcode off the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            opcode <= OP_NOP;
            step <= step_t'(1);
        end else if (last_step) begin
            opcode <= data_in;
            step <= '0;
        end else begin
            step <= step + step_t'(1);
        end
    end

    // One pulse per instruction, in its first step
    assign sync = (step == '0);

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::ctrl_flags_t flags,
    input  logic [7:0]           a_in,
    input  logic [7:0]           b_in,
    input  logic                 carry_in,
    output logic [7:0]           result,
    output logic                 carry_out
);
    import cpu_pkg::*;

    logic [8:0] sum;
    logic [7:0] next_result;
    logic       next_carry;

    always_comb begin
        sum = {1'b0, a_in} + {1'b0, b_in} + {8'h00, carry_in};
        if (flags[ALU_ADD]) begin
            next_result = sum[7:0];
            next_carry = sum[8];
        end else if (flags[ALU_ROT]) begin
            // Carry in enters at the top, bit 0 leaves as carry
            next_result = {carry_in, a_in[7:1]};
            next_carry = a_in[0];
        end else begin
            next_result = a_in;
            next_carry = carry_in;
        end
    end

    // Output register, read back by the datapath one step later
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            carry_out <= 1'b0;
        end else if (flags[LOAD_ALU]) begin
            result <= next_result;
            carry_out <= next_carry;
        end
    end

endmodule

`default_nettype wire

// ==== logic/register_datapath.sv ====
`default_nettype none
`timescale 1ns/100ps

module register_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::ctrl_flags_t flags,
    input  logic [7:0]           data_in,
    input  logic [7:0]           result,
    input  logic                 carry_out,
    output logic [7:0]           a_in,
    output logic [7:0]           b_in,
    output logic                 carry_in,
    output logic                 carry,
    output logic [15:0]          addr,
    output cpu_pkg::regs_t       regs
);
    import cpu_pkg::*;

    regs_t       regs_q;
    logic [7:0]  data_latch;
    logic [7:0]  sb_drive;
    logic [7:0]  db_drive;
    logic [7:0]  sb;
    logic [7:0]  db;
    logic [15:0] pc;
    logic [15:0] pc_next;
    logic [7:0]  adh;
    logic [7:0]  adl;
    logic [7:0]  abh;
    logic [7:0]  abl;

    // Byte read in the previous cycle
    always_ff @(posedge clk) begin
        data_latch <= data_in;
    end

    // Each bus is the OR of its enabled sources
    always_comb begin
        sb_drive = '0;
        db_drive = '0;
        if (flags[SET_SB_TO_ACC]) sb_drive = sb_drive | regs_q.a;
        if (flags[SET_SB_TO_X]) sb_drive = sb_drive | regs_q.x;
        if (flags[SET_SB_TO_Y]) sb_drive = sb_drive | regs_q.y;
        if (flags[SET_SB_TO_ALU]) sb_drive = sb_drive | result;
        if (flags[SET_DB_TO_ACC]) db_drive = db_drive | regs_q.a;
        if (flags[SET_DB_HIGH]) db_drive = 8'hFF;
        if (flags[SET_DB_TO_DATA]) db_drive = db_drive | data_latch;
    end

    // Bridge joins SB and DB in both directions
    always_comb begin
        if (flags[SET_DB_TO_SB]) begin
            sb = sb_drive | db_drive;
            db = sb_drive | db_drive;
        end else begin
            sb = sb_drive;
            db = db_drive;
        end
    end

    // ALU operands
    always_comb begin
        if (flags[SET_INPUT_A_TO_LOW]) begin
            a_in = '0;
        end else if (flags[SET_INPUT_A_TO_SB]) begin
            a_in = sb;
        end else begin
            a_in = '0;
        end
        b_in = flags[SET_INPUT_B_TO_DB] ? db : 8'h00;
        carry_in = flags[SET_ALU_CARRY_HIGH];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '0;
        end else begin
            if (flags[SET_ACC_TO_SB]) regs_q.a <= sb;
            if (flags[LOAD_X]) regs_q.x <= sb;
            if (flags[LOAD_Y]) regs_q.y <= sb;
            if (flags[LOAD_CARRY]) regs_q.carry <= carry_out;
        end
    end

    // Address buses carry the already incremented PC
    assign pc_next = flags[PC_INC] ? pc + 16'd1 : pc;
    assign adh = flags[SET_ADH_TO_PCH] ? pc_next[15:8] : 8'h00;
    assign adl = flags[SET_ADL_TO_PCL] ? pc_next[7:0] : 8'h00;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
            abh <= RESET_VECTOR[15:8];
            abl <= RESET_VECTOR[7:0];
        end else begin
            pc <= pc_next;
            if (flags[LOAD_ABH]) abh <= adh;
            if (flags[LOAD_ABL]) abl <= adl;
        end
    end

    assign addr = {abh, abl};
    assign carry = regs_q.carry;
    assign regs = regs_q;

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module cpu_core (
    input  logic           clk,
    input  logic           rst,
    input  logic [7:0]     data_in,
    output logic [15:0]    addr,
    output logic           sync,
    output cpu_pkg::regs_t regs
);
    import cpu_pkg::*;

    logic [7:0]  opcode;
    step_t       step;
    ctrl_flags_t flags;
    logic [7:0]  a_in;
    logic [7:0]  b_in;
    logic        carry_in;
    logic [7:0]  result;
    logic        carry_out;
    logic        carry;

    cycle_sequencer u_sequencer (
        .clk     (clk),
        .rst     (rst),
        .data_in (data_in),
        .opcode  (opcode),
        .step    (step),
        .sync    (sync)
    );

    implied_decode u_decode (
        .opcode (opcode),
        .step   (step),
        .carry  (carry),
        .flags  (flags)
    );

    alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .flags     (flags),
        .a_in      (a_in),
        .b_in      (b_in),
        .carry_in  (carry_in),
        .result    (result),
        .carry_out (carry_out)
    );

    register_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .flags     (flags),
        .data_in   (data_in),
        .result    (result),
        .carry_out (carry_out),
        .a_in      (a_in),
        .b_in      (b_in),
        .carry_in  (carry_in),
        .carry     (carry),
        .addr      (addr),
        .regs      (regs)
    );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset covers two rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/cpu_core_sva.sv ====
`default_nettype none
`timescale 1ns/100ps

module cpu_core_sva (
    input logic           clk,
    input logic           rst,
    input logic           sync,
    input logic [7:0]     opcode,
    input cpu_pkg::step_t step,
    input logic [15:0]    addr
);
    import cpu_pkg::*;

    logic imm_op;
    logic fetch_step;

    assign imm_op = (opcode == OP_LDA_IMM) || (opcode == OP_LDX_IMM) || (opcode == OP_LDY_IMM);

    // Steps that end with an address reload
    assign fetch_step = imm_op ? (step != step_t'(1)) : (step == step_t'(1));

    sync_single_cycle: assert property (@(posedge clk) disable iff (rst) sync |=> !sync)
        else $error("sync stayed high for two cycles in a row");

    addr_moves_on_fetch: assert property (@(posedge clk) disable iff (rst)
        (addr != $past(addr)) |-> $past(fetch_step))
        else $error("addr changed outside a fetch step");

    // First cycle out of reset is the opcode fetch
    sync_low_after_reset: assert property (@(posedge clk) ($past(rst) && !rst) |-> !sync)
        else $error("sync was high in the first cycle after reset");

endmodule

bind cpu_core cpu_core_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .sync   (sync),
    .opcode (opcode),
    .step   (step),
    .addr   (addr)
);

`default_nettype wire

// ==== bench/cpu_core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module cpu_core_tb;
    import cpu_pkg::*;

    logic        clk;
    logic        rst;
    logic [7:0]  data_in;
    logic [15:0] addr;
    logic        sync;
    regs_t       regs;

    logic [7:0]  mem [0:65535];
    logic [27:0] vec [0:63];
    int          seed;
    int          prog_len;
    int          snap_count;
    int          extra_nops;
    int          limit;
    int          cycles;
    int          sync_idx;
    int          since_sync;
    int          exp_cycles;
    logic [15:0] pc_exp;
    regs_t       expected;
    regs_t       last_snap;

    clock_gen u_clock (
        .clk (clk),
        .rst (rst)
    );

    cpu_core UUT (
        .clk     (clk),
        .rst     (rst),
        .data_in (data_in),
        .addr    (addr),
        .sync    (sync),
        .regs    (regs)
    );

    function automatic regs_t snapshot_from_word(logic [27:0] w);
        regs_t r;
        r.a = w[27:20];
        r.x = w[19:12];
        r.y = w[11:4];
        r.carry = w[0];
        return r;
    endfunction

    // Immediate loads take three cycles, everything else two
    function automatic int instr_cycles(logic [7:0] op);
        int n;
        if (op == OP_LDA_IMM || op == OP_LDX_IMM || op == OP_LDY_IMM) begin
            n = 3;
        end else begin
            n = 2;
        end
        return n;
    endfunction

    task automatic expect_value(input string name, input int want, input int got);
        assert (got == want) else begin
            $display("[FAIL] %s expected %0d actual %0d", name, want, got);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_regs(input string name, input regs_t want);
        assert (regs === want) else begin
            $display("[FAIL] %s expected a=%h x=%h y=%h c=%b actual a=%h x=%h y=%h c=%b",
                     name, want.a, want.x, want.y, want.carry,
                     regs.a, regs.x, regs.y, regs.carry);
            $display("test failed");
            $fatal(1, "register snapshot mismatch");
        end
    endtask

    // Memory answers on the falling edge
    initial begin
        data_in = OP_NOP;
        forever begin
            @(negedge clk);
            data_in <= mem[addr];
        end
    end

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the program did not finish within %0d cycles", limit);
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed = 16730;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = OP_NOP;
        end
        $readmemh("bench/cpu_core_input.txt", vec);
        prog_len = int'(vec[0]);
        snap_count = int'(vec[1]);
        for (int i = 0; i < prog_len; i++) begin
            mem[16'(int'(RESET_VECTOR) + i)] = vec[2 + i][7:0];
        end
        // Trailing NOPs come from the unlisted bytes
        extra_nops = int'($unsigned($random(seed)) % 4);
        limit = 3 * prog_len + 20;
        pc_exp = RESET_VECTOR;
        sync_idx = 0;
        since_sync = 0;
        exp_cycles = 0;
        last_snap = '0;
        wait (!rst);
        while (sync_idx <= snap_count + extra_nops) begin
            @(negedge clk);
            since_sync++;
            if (sync) begin
                if (sync_idx > 0) begin
                    expect_value($sformatf("length of instruction %0d", sync_idx - 1),
                                 exp_cycles, since_sync);
                end
                expect_value($sformatf("addr at sync %0d", sync_idx),
                             int'(pc_exp) + 1, int'(addr));
                // Each sync shows what the instruction before it left behind
                if (sync_idx == 0) begin
                    expected = '0;
                end else if (sync_idx <= snap_count) begin
                    expected = snapshot_from_word(vec[1 + prog_len + sync_idx]);
                    last_snap = expected;
                end else begin
                    expected = last_snap;
                end
                compare_regs($sformatf("regs at sync %0d", sync_idx), expected);
                exp_cycles = instr_cycles(mem[pc_exp]);
                pc_exp = pc_exp + 16'(exp_cycles - 1);
                since_sync = 0;
                sync_idx++;
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_core.f ====
logic/cpu_pkg.sv
logic/implied_decode.sv
logic/cycle_sequencer.sv
logic/alu.sv
logic/register_datapath.sv
logic/cpu_core.sv
bench/clock_gen.sv
bench/cpu_core_sva.sv
bench/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = cpu_core_tb
FILELIST  = cpu_core.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/cpu_core_input.txt ====
// Word 0 is the program length in bytes, word 1 the number of snapshots
// Then program bytes from the reset vector, then one snapshot aaxxyyc per instruction
14 10
A9 81 0A        // LDA #81, ASL A
A2 FF E8 CA     // LDX #FF, INX, DEX
2A A0 00 88 C8  // ROL A, LDY #00, DEY, INY
4A 6A 6A 2A     // LSR A, ROR A, ROR A, ROL A
EA A2 7F E8     // NOP, LDX #7F, INX
8100000 0200001 02FF001 0200001   // LDA ASL LDX INX
02FF001 05FF000 05FF000 05FFFF0   // DEX ROL LDY DEY
05FF000 02FF001 81FF000 40FF001   // INY LSR ROR ROR
81FF000 81FF000 817F000 8180000   // ROL NOP LDX INX
